// File: hdl/cart_hdr_cfg.svh
// Cartridge header inspector configuration
// Download bus widths, header word addresses and light-gun defaults

`ifndef CART_HDR_CFG_SVH
`define CART_HDR_CFG_SVH

// Download bus
`define CART_ADDR_W        25
`define CART_DATA_W        16

// Header word addresses, byte addressed
`define HDR_ID_ADDR        25'h180  // First product code word
`define HDR_ID_LAST        25'h18A  // Last product code word, low byte only
`define HDR_CRC_ADDR       25'h18E
`define HDR_ID_DONE_ADDR   25'h190  // Product code complete
`define HDR_RGN_ADDR0      25'h1F0
`define HDR_RGN_ADDR1      25'h1F2
`define HDR_END_ADDR       25'h200

`define GUN_DELAY_DEFAULT  8'd44

`endif

// File: hdl/cart_hdr_pkg.sv
// Cartridge header inspector types
// Region, priority and gun enums plus the structs passed between stages

`include "cart_hdr_cfg.svh"

package cart_hdr_pkg;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_e;

	// Region search order when several header flags are set
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_e;

	typedef enum logic {
		MENACER   = 1'b0,
		JUSTIFIER = 1'b1
	} gun_type_e;

	typedef enum logic {
		WAIT_HDR = 1'b0,
		HOLD     = 1'b1
	} sel_state_e;

	// One word from the ROM loader
	typedef struct packed {
		logic [`CART_ADDR_W-1:0] addr;
		logic [`CART_DATA_W-1:0] data;
		logic                    strb;
	} load_wr_t;

	typedef struct packed {
		logic [87:0] id;    // 11 characters, first one on top
		logic [15:0] crc;
		logic        j;
		logic        u;
		logic        e;
	} hdr_fields_t;

	typedef struct packed {
		logic [3:0] eeprom_map;
		logic       noram_quirk;
		logic       fmbusy_quirk;
		logic       schan_quirk;
		logic [2:0] sf_map;      // Bootleg bank map
		gun_type_e  gun_type;
		logic [7:0] gun_delay;   // Sensor delay in pixels
	} cart_profile_t;

endpackage

// File: hdl/hdr_capture.sv
// Cartridge header capture
// Watches the ROM download stream, byte-swaps the product code and checksum
// words, decodes the region characters and flags header completion.
// Also latches the ROM size when the download ends.

`include "cart_hdr_cfg.svh"

module hdr_capture (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       dl_active,
	input  cart_hdr_pkg::load_wr_t     wr,
	output cart_hdr_pkg::hdr_fields_t  hdr,
	output logic                       id_done,
	output logic                       dl_start,
	output logic                       hdr_ready,
	output logic [`CART_ADDR_W-1:0]    rom_size
);
	import cart_hdr_pkg::*;

	logic                    dl_active_d;
	logic                    dl_end;
	logic                    wr_en;
	logic [`CART_DATA_W-1:0] data_sw;
	logic [7:0]              lo;
	logic [7:0]              hi;
	logic [3:0]              hrgn;
	logic [87:0]             id_q;
	logic [15:0]             crc_q;
	logic [2:0]              rgn_q;     // {e, u, j}
	logic [2:0]              rgn_next;
	logic [`CART_ADDR_W-1:0] last_addr;

	// Letter to flag position {e, u, j}
	function automatic logic [2:0] letter_euj(input logic [7:0] c);
		return {c == "E", c == "U", c == "J"};
	endfunction

	assign dl_start = dl_active & ~dl_active_d;
	assign dl_end   = ~dl_active & dl_active_d;
	assign wr_en    = wr.strb & dl_active;
	assign data_sw  = {wr.data[7:0], wr.data[15:8]};  // Earlier char sits in low byte
	assign lo       = wr.data[7:0];
	assign hi       = wr.data[15:8];
	assign hrgn     = wr.data[3:0] - 4'd7;              // 'A'..'F' to 10..15

	assign hdr = '{id: id_q, crc: crc_q, j: rgn_q[0], u: rgn_q[1], e: rgn_q[2]};

	////////////////////////////////////////
	// Region character decode

	always_comb begin
		rgn_next = rgn_q;
		if (wr.addr == `HDR_RGN_ADDR0) begin
			if (|letter_euj(lo))
				rgn_next = rgn_q | letter_euj(lo);
			else if (lo >= "0" && lo <= "9")
				rgn_next = {lo[3], lo[2], lo[0]};
			else if (lo >= "A" && lo <= "F")
				rgn_next = {hrgn[3], hrgn[2], hrgn[0]};
			rgn_next = rgn_next | letter_euj(hi);   // Second character
		end
		if (wr.addr == `HDR_RGN_ADDR1)
			rgn_next = rgn_q | letter_euj(lo);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || dl_start)
			rgn_q <= '0;
		else if (wr_en)
			rgn_q <= rgn_next;
	end

	////////////////////////////////////////
	// Product code and checksum words

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			for (int k = 0; k < 5; k++) begin
				if (wr.addr == `HDR_ID_ADDR + 2 * k)
					id_q[87 - 16 * k -: 16] <= data_sw;
			end
			if (wr.addr == `HDR_ID_LAST)
				id_q[7:0] <= lo;                    // 11th char only
			if (wr.addr == `HDR_CRC_ADDR)
				crc_q <= data_sw;
			last_addr <= wr.addr;
		end
	end

	////////////////////////////////////////
	// Download edges, header status and size

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_active_d <= 1'b0;
			id_done     <= 1'b0;
			hdr_ready   <= 1'b0;
			rom_size    <= '0;
		end else begin
			dl_active_d <= dl_active;
			id_done     <= wr_en && (wr.addr == `HDR_ID_DONE_ADDR);
			if (wr_en && (wr.addr == `HDR_END_ADDR))
				hdr_ready <= 1'b1;
			if (dl_end) begin
				hdr_ready <= 1'b0;
				rom_size  <= last_addr;
			end
		end
	end

	// Loader only strobes inside a download
	a_wr_in_dl: assert property (@(posedge clk_sys) disable iff (RESET)
		wr.strb |-> dl_active)
		else $error("wr strobe seen with dl_active low");

endmodule

// File: hdl/cart_profile.sv
// Cartridge profile lookup
// Matches the captured product code against the known cartridge table and
// loads the EEPROM map, quirk bits, bootleg map and light-gun settings.
// Returns to defaults at the start of every download.

`include "cart_hdr_cfg.svh"

module cart_profile (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        dl_start,
	input  logic                        id_done,
	input  cart_hdr_pkg::hdr_fields_t   hdr,
	output cart_hdr_pkg::cart_profile_t profile
);
	import cart_hdr_pkg::*;

	localparam cart_profile_t PROFILE_DEFAULT = '{
		eeprom_map:   4'b0000,
		noram_quirk:  1'b0,
		fmbusy_quirk: 1'b0,
		schan_quirk:  1'b0,
		sf_map:       3'b000,
		gun_type:     MENACER,
		gun_delay:    `GUN_DELAY_DEFAULT
	};

	logic [63:0]   code8;   // Low 8 characters of the id
	logic [47:0]   code6;   // Top 6 characters
	cart_profile_t match;

	assign code8 = hdr.id[63:0];
	assign code6 = hdr.id[87:40];

	always_comb begin
		match = PROFILE_DEFAULT;

		// Mapper and quirk table
		case (code8)
			"T-50446 ": match.eeprom_map   = 4'b0001;
			"MK-1215 ": match.eeprom_map   = 4'b0010;
			"T-081326": match.eeprom_map   = 4'b0011;
			"T-081276": match.eeprom_map   = 4'b1011;
			"T-081586": match.eeprom_map   = 4'b1100;
			"T-81576 ": match.eeprom_map   = 4'b1101;
			"T-113016": match.noram_quirk  = 1'b1;   // Fake RAM check
			"T-35036 ": match.fmbusy_quirk = 1'b1;
			"T-68???-": match.schan_quirk  = 1'b1;
			default: begin
				if (code6 == "SF-001")
					match.sf_map = {hdr.crc == 16'h3E08, 2'b01};  // Revision by checksum
				else if (code6 == "SF-002")
					match.sf_map = 3'b110;
				else if (code6 == "SF-004")
					match.sf_map = 3'b111;
			end
		endcase

		// Light-gun type and sensor delay
		case (code8)
			"MK-1533 ": begin
				match.gun_type  = MENACER;
				match.gun_delay = 8'd100;
			end
			"T-95096-": begin
				match.gun_type  = JUSTIFIER;
				match.gun_delay = 8'd52;
			end
			"T-95136-": begin
				match.gun_type  = JUSTIFIER;
				match.gun_delay = 8'd30;
			end
			"MK-1658 ": begin
				match.gun_type  = MENACER;
				match.gun_delay = 8'd120;
			end
			default: ;  // Menacer at default delay
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || dl_start)
			profile <= PROFILE_DEFAULT;
		else if (id_done)
			profile <= match;
	end

	a_eeprom_code: assert property (@(posedge clk_sys) disable iff (RESET)
		profile.eeprom_map inside {4'b0000, 4'b0001, 4'b0010, 4'b0011,
			4'b1011, 4'b1100, 4'b1101})
		else $error("eeprom_map holds unused code %h", profile.eeprom_map);

endmodule

// File: hdl/region_select.sv
// Console region selector
// Once the header is complete, picks the first flagged region in the user
// priority order and holds the request until the header is released

module region_select (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  logic                       hdr_ready,
	input  logic                       auto_region_off,
	input  cart_hdr_pkg::hdr_fields_t  hdr,
	input  cart_hdr_pkg::region_prio_e region_prio,
	output cart_hdr_pkg::region_e      region_req,
	output logic                       region_set
);
	import cart_hdr_pkg::*;

	sel_state_e state;

	function automatic region_e pick_region(input region_prio_e prio,
		input logic j, input logic u, input logic e);
		region_e r;
		case (prio)
			PRIO_US_EU_JP: r = u ? US : e ? EU : j ? JP : US;
			PRIO_EU_US_JP: r = e ? EU : u ? US : j ? JP : EU;
			PRIO_US_JP_EU: r = u ? US : j ? JP : e ? EU : US;
			default:       r = j ? JP : u ? US : e ? EU : JP;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= WAIT_HDR;
			region_req <= JP;
			region_set <= 1'b0;
		end else begin
			case (state)
				WAIT_HDR: begin
					if (hdr_ready) begin
						state      <= HOLD;
						region_set <= ~auto_region_off;
						if (!auto_region_off)
							region_req <= pick_region(region_prio, hdr.j, hdr.u, hdr.e);
					end
				end
				HOLD: begin
					if (!hdr_ready) begin   // Download finished
						state      <= WAIT_HDR;
						region_set <= 1'b0;
					end
				end
				default: state <= WAIT_HDR;
			endcase
		end
	end

	a_region_valid: assert property (@(posedge clk_sys) disable iff (RESET)
		region_set |-> (region_req != 2'd3))
		else $error("region_req is 3 while region_set is high");

endmodule

// File: hdl/cart_hdr_top.sv
// Cartridge header inspector top level
// Header capture feeds the profile lookup and the region selector

`include "cart_hdr_cfg.svh"

module cart_hdr_top (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        dl_active,
	input  cart_hdr_pkg::load_wr_t      wr,
	input  cart_hdr_pkg::region_prio_e  region_prio,
	input  logic                        auto_region_off,
	output cart_hdr_pkg::region_e       region_req,
	output logic                        region_set,
	output cart_hdr_pkg::cart_profile_t profile,
	output logic [`CART_ADDR_W-1:0]     rom_size
);
	import cart_hdr_pkg::*;

	hdr_fields_t hdr;
	logic        id_done;
	logic        dl_start;
	logic        hdr_ready;

	hdr_capture u_capture (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_active (dl_active),
		.wr        (wr),
		.hdr       (hdr),
		.id_done   (id_done),
		.dl_start  (dl_start),
		.hdr_ready (hdr_ready),
		.rom_size  (rom_size)
	);

	cart_profile u_profile (
		.clk_sys  (clk_sys),
		.RESET    (RESET),
		.dl_start (dl_start),
		.id_done  (id_done),
		.hdr      (hdr),
		.profile  (profile)
	);

	region_select u_region (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.hdr_ready       (hdr_ready),
		.auto_region_off (auto_region_off),
		.hdr             (hdr),
		.region_prio     (region_prio),
		.region_req      (region_req),
		.region_set      (region_set)
	);

endmodule

// File: testbench/tb_clkgen.sv
// Testbench clock source
// Free-running clock with a configurable period

module tb_clkgen #(
	parameter int PERIOD = 8
) (
	output logic clk_sys
);
	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;  // Half period per phase
	end
endmodule

// File: testbench/tb_cart_hdr.sv
// Cartridge header inspector testbench
// Plays one full ROM download per table row and checks the region request,
// the cartridge profile, region_set and the latched ROM size

`include "cart_hdr_cfg.svh"

module tb_cart_hdr;
	import cart_hdr_pkg::*;

	typedef struct packed {
		logic [87:0]             id;
		logic [15:0]             crc;
		logic [23:0]             rgn;        // 0x1F0 low, 0x1F0 high, 0x1F2 low
		region_prio_e            prio;
		logic                    auto_off;
		logic [`CART_ADDR_W-1:0] last_addr;
		region_e                 exp_rgn;
		logic                    exp_set;
		cart_profile_t           exp_prof;
	} row_t;

	logic                    clk_sys;
	logic                    RESET;
	logic                    dl_active;
	load_wr_t                wr;
	region_prio_e            region_prio;
	logic                    auto_region_off;
	region_e                 region_req;
	logic                    region_set;
	cart_profile_t           profile;
	logic [`CART_ADDR_W-1:0] rom_size;

	row_t    rows[$];
	integer  seed;
	int      err_val;
	int      err_other;
	int      cur_row;
	int      set_cycles = 0;
	longint  limit;
	logic    table_ready = 1'b0;

	tb_clkgen #(.PERIOD(8)) clkgen0 (.clk_sys(clk_sys));

	cart_hdr_top dut0 (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.dl_active       (dl_active),
		.wr              (wr),
		.region_prio     (region_prio),
		.auto_region_off (auto_region_off),
		.region_req      (region_req),
		.region_set      (region_set),
		.profile         (profile),
		.rom_size        (rom_size)
	);

	always @(negedge clk_sys) begin
		if (region_set)
			set_cycles <= set_cycles + 1;  // High cycles seen by the auto-off rows
	end

	function automatic cart_profile_t make_profile(input logic [3:0] ee,
		input logic [2:0] quirks, input logic [2:0] sf, input gun_type_e gun,
		input logic [7:0] dly);
		cart_profile_t p;
		p = '{ee, quirks[2], quirks[1], quirks[0], sf, gun, dly};
		return p;
	endfunction

	// Word image of the header for one row
	function automatic logic [15:0] header_word(input row_t t,
		input logic [`CART_ADDR_W-1:0] a, input logic [15:0] filler);
		logic [15:0] w;
		w = (a >= `HDR_ID_ADDR && a < `HDR_END_ADDR) ? 16'h0000 : filler;
		for (int k = 0; k < 5; k++) begin
			if (a == 25'(`HDR_ID_ADDR + 2 * k))
				w = {t.id[79 - 16 * k -: 8], t.id[87 - 16 * k -: 8]};  // Earlier char low
		end
		if (a == `HDR_ID_LAST)
			w = {8'h00, t.id[7:0]};
		if (a == `HDR_CRC_ADDR)
			w = {t.crc[7:0], t.crc[15:8]};
		if (a == `HDR_RGN_ADDR0)
			w = {t.rgn[15:8], t.rgn[23:16]};
		if (a == `HDR_RGN_ADDR1)
			w = {8'h00, t.rgn[7:0]};
		return w;
	endfunction

	////////////////////////////////////////
	// Compare tasks

	task automatic check_region(input region_e got, input region_e exp);
		if (got !== exp) begin
			$display("[ERROR] row %0d region_req: got %h expected %h", cur_row, got, exp);
			err_val++;
		end
	endtask

	task automatic check_profile(input cart_profile_t got, input cart_profile_t exp);
		if (got !== exp) begin
			$display("[ERROR] row %0d profile: got %h expected %h", cur_row, got, exp);
			err_val++;
		end
	endtask

	task automatic check_size(input logic [`CART_ADDR_W-1:0] got,
		input logic [`CART_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] row %0d rom_size: got %h expected %h", cur_row, got, exp);
			err_val++;
		end
	endtask

	task automatic check_set(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] row %0d %s: got %h expected %h", cur_row, name, got, exp);
			err_val++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus table

	task automatic add_row(input logic [87:0] id, input logic [15:0] crc,
		input logic [23:0] rgn, input logic [1:0] prio, input logic auto_off,
		input logic [`CART_ADDR_W-1:0] last_addr, input region_e exp_rgn,
		input logic exp_set, input logic [3:0] ee, input logic [2:0] quirks,
		input logic [2:0] sf, input gun_type_e gun, input logic [7:0] dly);
		row_t r;
		r = '{id, crc, rgn, region_prio_e'(prio), auto_off, last_addr, exp_rgn, exp_set,
			make_profile(ee, quirks, sf, gun, dly)};
		rows.push_back(r);
	endtask

	task automatic build_table();
		// id, crc, region chars, prio, auto off, last addr, region, set,
		// eeprom, {noram, fmbusy, schan}, sf_map, gun, delay
		add_row("GM T-50446 ", 'h1234, "JUE", 0, 0, 'h200, US, 1, 'h1, 0, 0, MENACER, 44);
		add_row("GM MK-1215 ", 'h0BAD, "JE ", 1, 0, 'h220, EU, 1, 'h2, 0, 0, MENACER, 44);
		add_row("GM T-081326", 'h5A5A, "  U", 3, 0, 'h200, US, 1, 'h3, 0, 0, MENACER, 44);
		add_row("GM T-113016", 'h0001, "EJ ", 2, 0, 'h240, JP, 1, 0, 'b100, 0, MENACER, 44);
		add_row("GM T-35036 ", 'h0002, "1  ", 0, 0, 'h200, JP, 1, 0, 'b010, 0, MENACER, 44);
		add_row("GM T-68???-", 'h0003, "4  ", 3, 0, 'h210, US, 1, 0, 'b001, 0, MENACER, 44);
		add_row("SF-001     ", 'h3E08, "8  ", 2, 0, 'h200, EU, 1, 0, 0, 'b101, MENACER, 44);
		add_row("SF-001     ", 'h1111, "A  ", 0, 0, 'h200, EU, 1, 0, 0, 'b001, MENACER, 44);
		add_row("SF-002     ", 'h2222, "F  ", 3, 0, 'h200, JP, 1, 0, 0, 'b110, MENACER, 44);
		add_row("SF-004     ", 'h3333, "XYZ", 1, 0, 'h200, EU, 1, 0, 0, 'b111, MENACER, 44);
		// Auto region off keeps the request of the row before
		add_row("GM MK-1533 ", 'h4444, "U  ", 0, 1, 'h220, EU, 0, 0, 0, 0, MENACER, 100);
		add_row("GM T-95096-", 'h5555, "UJE", 2, 0, 'h200, US, 1, 0, 0, 0, JUSTIFIER, 52);
		add_row("GM T-95136-", 'h6666, "EUJ", 3, 0, 'h200, JP, 1, 0, 0, 0, JUSTIFIER, 30);
		add_row("GM MK-1658 ", 'h7777, " E ", 0, 0, 'h200, EU, 1, 0, 0, 0, MENACER, 120);
		add_row("GM T-12345 ", 'h8888, "   ", 2, 0, 'h230, US, 1, 0, 0, 0, MENACER, 44);
		add_row("GM T-081276", 'h9999, "U  ", 1, 0, 'h200, US, 1, 'hB, 0, 0, MENACER, 44);
		add_row("GM T-081586", 'hAAAA, "E  ", 3, 0, 'h200, EU, 1, 'hC, 0, 0, MENACER, 44);
		add_row("GM T-81576 ", 'hBBBB, "J  ", 0, 0, 'h200, JP, 1, 'hD, 0, 0, MENACER, 44);
	endtask

	// One full download of a row and its release
	task automatic run_row(input row_t t);
		logic [`CART_ADDR_W-1:0] a;
		logic [15:0]             filler;
		int                      n;
		int                      set_start;
		set_start = set_cycles;
		for (a = '0; a <= t.last_addr; a = a + 2) begin
			@(posedge clk_sys);
			filler          = $random(seed);
			dl_active       <= 1'b1;
			region_prio     <= t.prio;
			auto_region_off <= t.auto_off;
			wr              <= '{addr: a, data: header_word(t, a, filler), strb: 1'b1};
			if (a == 25'h100) begin
				@(negedge clk_sys);
				check_profile(profile, make_profile(0, 0, 0, MENACER, `GUN_DELAY_DEFAULT));
			end
		end
		@(posedge clk_sys);
		wr <= '0;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (t.exp_set && !region_set && n < 4);
		if (t.exp_set && !region_set) begin
			$display("Row %0d: region_set never rose after the header", cur_row);
			err_other++;
		end else begin
			check_region(region_req, t.exp_rgn);
		end
		check_profile(profile, t.exp_prof);
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (3) @(negedge clk_sys);
		check_size(rom_size, t.last_addr);
		check_set("region_set", region_set, 1'b0);
		if (!t.exp_set)
			check_set("region_set during download", set_cycles != set_start, 1'b0);
	endtask

	////////////////////////////////////////
	// Watchdog and main sequence

	initial begin
		wait (table_ready);
		#(limit);
		$display("Watchdog expired at time %0t, the run stalled", $time);
		$display("Checks failed");
		$finish;
	end

	initial begin
		seed            = 32'hcf9a;
		err_val         = 0;
		err_other       = 0;
		cur_row         = -1;
		RESET           <= 1'b1;
		dl_active       <= 1'b0;
		wr              <= '0;
		region_prio     <= PRIO_US_EU_JP;
		auto_region_off <= 1'b0;
		build_table();
		limit = 8 * 8;                                // Reset time
		foreach (rows[i])
			limit += (rows[i].last_addr / 2 + 20) * 8;
		table_ready = 1'b1;

		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_profile(profile, make_profile(0, 0, 0, MENACER, `GUN_DELAY_DEFAULT));
		check_region(region_req, JP);
		check_set("region_set", region_set, 1'b0);
		check_size(rom_size, '0);

		foreach (rows[i]) begin
			cur_row = i;
			run_row(rows[i]);
		end

		$display("Summary: %0d value errors, %0d other errors over %0d rows",
			err_val, err_other, rows.size());
		if (err_val == 0 && err_other == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+hdl
hdl/cart_hdr_pkg.sv
hdl/hdr_capture.sv
hdl/cart_profile.sv
hdl/region_select.sv
hdl/cart_hdr_top.sv
testbench/tb_clkgen.sv
testbench/tb_cart_hdr.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cart_hdr
FILELIST  ?= tb.f
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
